/* include/dcache_params.svh */
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

`define DC_ADDR_W     32
`define DC_WORD_W     32
`define DC_LINES      128
`define DC_INDEX_W    7
`define DC_WORDS      16
`define DC_OFFSET_W   4
`define DC_TAG_W      19
`define DC_BE_W       4

// Address split, byte bits below the word offset
`define DC_OFFSET_LSB 2
`define DC_INDEX_LSB  6
`define DC_TAG_LSB    13

`endif

/* logic/dcache_pkg.sv */
`default_nettype none

`include "dcache_params.svh"

package dcache_pkg;

    typedef logic [`DC_ADDR_W-1:0]            addr_t;
    typedef logic [`DC_WORD_W-1:0]            word_t;
    typedef logic [`DC_TAG_W-1:0]             tag_t;
    typedef logic [`DC_INDEX_W-1:0]           index_t;
    typedef logic [`DC_OFFSET_W-1:0]          offset_t;
    typedef logic [`DC_BE_W-1:0]              be_t;
    typedef logic [`DC_WORDS*`DC_WORD_W-1:0]  line_t;

    typedef enum logic [2:0] {
        IDLE,
        MISS_SHAKE,   // Line read not yet accepted
        MISS_WAIT,
        WB_WAIT,      // Refill done, victim still draining
        REFILL
    } ctrl_state_e;

    typedef enum logic [1:0] {
        WB_IDLE,
        WB_SHAKE,
        WB_WRITE,
        WB_RESULT
    } wb_state_e;

    // Replace the bytes of old_word selected by be
    function automatic word_t merge_bytes(word_t old_word, word_t new_word, be_t be);
        word_t result;
        result = old_word;
        for (int b = 0; b < `DC_BE_W; b++) begin
            if (be[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

endpackage

`default_nettype wire

/* logic/dcache_line_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_line_store import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  addr_t  daddr,
    input  logic   line_we,
    input  line_t  fill_line,
    input  logic   store_hit_we,
    input  be_t    dwen,
    input  word_t  wdata,
    input  logic   set_dirty,
    output logic   hit,
    output line_t  rd_line,
    output tag_t   victim_tag,
    output logic   victim_dirty
);

    line_t                 data_mem [`DC_LINES];
    tag_t                  tag_mem  [`DC_LINES];
    logic [`DC_LINES-1:0]  valid;
    logic [`DC_LINES-1:0]  dirty;

    tag_t     tag;
    index_t   idx;
    offset_t  off;
    word_t    old_word;

    assign tag = daddr[`DC_ADDR_W-1:`DC_TAG_LSB];
    assign idx = daddr[`DC_TAG_LSB-1:`DC_INDEX_LSB];
    assign off = daddr[`DC_INDEX_LSB-1:`DC_OFFSET_LSB];

    // Combinational read of the indexed line
    assign rd_line      = data_mem[idx];
    assign victim_tag   = tag_mem[idx];
    assign victim_dirty = valid[idx] & dirty[idx];
    assign hit          = valid[idx] && (tag_mem[idx] == tag);

    assign old_word = rd_line[off*`DC_WORD_W +: `DC_WORD_W];

    always_ff @(posedge clk) begin
        if (line_we) begin
            data_mem[idx] <= fill_line;
            tag_mem[idx]  <= tag;
        end else if (store_hit_we) begin
            data_mem[idx][off*`DC_WORD_W +: `DC_WORD_W] <= merge_bytes(old_word, wdata, dwen);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            dirty <= '0;
        end else if (line_we) begin
            valid[idx] <= 1'b1;
            dirty[idx] <= set_dirty;   // Dirty right away on a store miss
        end else if (store_hit_we) begin
            dirty[idx] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/dcache_refill.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_refill import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   refill_active,
    input  addr_t  daddr,
    input  be_t    dwen,
    input  word_t  wdata,
    input  logic   ddata_rvalid,
    input  word_t  ddata_rdata,
    output line_t  fill_line
);

    offset_t  beat_cnt;
    offset_t  off;
    line_t    line_buf;
    word_t    beat_word;

    assign off = daddr[`DC_INDEX_LSB-1:`DC_OFFSET_LSB];

    // Store data lands in the missing word as it arrives
    assign beat_word = (beat_cnt == off) ? merge_bytes(ddata_rdata, wdata, dwen)
                                         : ddata_rdata;

    always_ff @(posedge clk) begin
        if (rst || !refill_active) begin
            beat_cnt <= '0;
        end else if (ddata_rvalid) begin
            beat_cnt <= beat_cnt + 1'b1;   // Wraps back to 0 after the last beat
        end
    end

    always_ff @(posedge clk) begin
        if (refill_active && ddata_rvalid) begin
            line_buf[beat_cnt*`DC_WORD_W +: `DC_WORD_W] <= beat_word;
        end
    end

    assign fill_line = line_buf;

endmodule

`default_nettype wire

/* logic/dcache_writeback.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_writeback import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   wb_start,
    input  tag_t   victim_tag,
    input  addr_t  daddr,
    input  line_t  rd_line,
    input  logic   daddr_wreq_ok,
    input  logic   ddata_wready,
    input  logic   ddata_bvalid,
    output logic   wb_busy,
    output logic   write_en,
    output addr_t  daddr_wreq,
    output be_t    write_byte_en,
    output logic   dwvalid,
    output word_t  dwdata,
    output logic   dwlast
);

    wb_state_e  state;
    wb_state_e  next_state;
    offset_t    out_cnt;
    index_t     idx;
    addr_t      victim_addr;

    assign idx         = daddr[`DC_TAG_LSB-1:`DC_INDEX_LSB];
    assign victim_addr = {victim_tag, idx, {`DC_INDEX_LSB{1'b0}}};

    assign wb_busy = (state != WB_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WB_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || state != WB_WRITE) begin
            out_cnt <= '0;
        end else if (ddata_wready) begin
            out_cnt <= out_cnt + 1'b1;
        end
    end

    always_comb begin
        next_state    = state;
        write_en      = 1'b0;
        daddr_wreq    = '0;
        write_byte_en = '0;
        dwvalid       = 1'b0;
        dwdata        = '0;
        dwlast        = 1'b0;

        case (state)
            WB_IDLE: begin
                if (wb_start) begin
                    write_en   = 1'b1;   // Address goes out in the start cycle
                    daddr_wreq = victim_addr;
                    next_state = daddr_wreq_ok ? WB_WRITE : WB_SHAKE;
                end
            end
            WB_SHAKE: begin
                write_en   = 1'b1;
                daddr_wreq = victim_addr;
                if (daddr_wreq_ok) begin
                    next_state = WB_WRITE;
                end
            end
            WB_WRITE: begin
                dwvalid       = 1'b1;
                write_byte_en = '1;
                dwdata        = rd_line[out_cnt*`DC_WORD_W +: `DC_WORD_W];
                dwlast        = &out_cnt;
                if (ddata_wready && dwlast) begin
                    next_state = WB_RESULT;
                end
            end
            WB_RESULT: begin
                if (ddata_bvalid) begin
                    next_state = WB_IDLE;
                end
            end
            default: next_state = WB_IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* logic/dcache_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   den,
    input  be_t    dwen,
    input  addr_t  daddr,
    input  logic   hit,
    input  logic   victim_dirty,
    input  line_t  rd_line,
    input  line_t  fill_line,
    input  logic   wb_busy,
    input  logic   daddr_req_ok,
    input  logic   ddata_rvalid,
    input  logic   ddata_rlast,
    output logic   data_ok,
    output word_t  data_data,
    output logic   busy,
    output logic   read_en,
    output addr_t  daddr_req,
    output logic   refill_active,
    output logic   wb_start,
    output logic   line_we,
    output logic   store_hit_we,
    output logic   set_dirty
);

    ctrl_state_e  state;
    ctrl_state_e  next_state;
    offset_t      off;
    addr_t        line_addr;
    word_t        hit_word;
    word_t        fill_word;

    assign off       = daddr[`DC_INDEX_LSB-1:`DC_OFFSET_LSB];
    assign line_addr = {daddr[`DC_ADDR_W-1:`DC_INDEX_LSB], {`DC_INDEX_LSB{1'b0}}};
    assign hit_word  = rd_line[off*`DC_WORD_W +: `DC_WORD_W];
    assign fill_word = fill_line[off*`DC_WORD_W +: `DC_WORD_W];

    // Collector runs from the read request until the last beat
    assign refill_active = (state == MISS_SHAKE) || (state == MISS_WAIT);

    assign busy = (state != IDLE) || (den && !hit);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state   = state;
        data_ok      = 1'b0;
        data_data    = '0;
        read_en      = 1'b0;
        daddr_req    = '0;
        wb_start     = 1'b0;
        line_we      = 1'b0;
        store_hit_we = 1'b0;
        set_dirty    = 1'b0;

        case (state)
            IDLE: begin
                if (den && hit) begin
                    data_ok      = 1'b1;
                    data_data    = hit_word;
                    store_hit_we = |dwen;
                end else if (den) begin
                    read_en    = 1'b1;
                    daddr_req  = line_addr;
                    wb_start   = victim_dirty;   // Victim drains while the refill arrives
                    next_state = daddr_req_ok ? MISS_WAIT : MISS_SHAKE;
                end
            end
            MISS_SHAKE: begin
                read_en   = 1'b1;
                daddr_req = line_addr;
                if (daddr_req_ok) begin
                    next_state = MISS_WAIT;
                end
            end
            MISS_WAIT: begin
                if (ddata_rvalid && ddata_rlast) begin
                    next_state = wb_busy ? WB_WAIT : REFILL;
                end
            end
            WB_WAIT: begin
                if (!wb_busy) begin
                    next_state = REFILL;
                end
            end
            REFILL: begin
                line_we    = 1'b1;
                set_dirty  = |dwen;
                data_ok    = 1'b1;
                data_data  = fill_word;
                next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

endmodule

`default_nettype wire

/* logic/dcache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    // Processor side
    input  logic   den,
    input  be_t    dwen,
    input  addr_t  daddr,
    input  word_t  wdata,
    output logic   data_ok,
    output word_t  data_data,
    output logic   busy,
    // Read channel
    output logic   read_en,
    output addr_t  daddr_req,
    input  logic   daddr_req_ok,
    input  word_t  ddata_rdata,
    input  logic   ddata_rvalid,
    input  logic   ddata_rlast,
    // Write channel
    output logic   write_en,
    output addr_t  daddr_wreq,
    output be_t    write_byte_en,
    output logic   dwvalid,
    output word_t  dwdata,
    output logic   dwlast,
    input  logic   daddr_wreq_ok,
    input  logic   ddata_wready,
    input  logic   ddata_bvalid
);

    logic   hit;
    logic   victim_dirty;
    tag_t   victim_tag;
    line_t  rd_line;
    line_t  fill_line;
    logic   refill_active;
    logic   wb_start;
    logic   wb_busy;
    logic   line_we;
    logic   store_hit_we;
    logic   set_dirty;

    dcache_ctrl i_ctrl (
        .clk           (clk),
        .rst           (rst),
        .den           (den),
        .dwen          (dwen),
        .daddr         (daddr),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .rd_line       (rd_line),
        .fill_line     (fill_line),
        .wb_busy       (wb_busy),
        .daddr_req_ok  (daddr_req_ok),
        .ddata_rvalid  (ddata_rvalid),
        .ddata_rlast   (ddata_rlast),
        .data_ok       (data_ok),
        .data_data     (data_data),
        .busy          (busy),
        .read_en       (read_en),
        .daddr_req     (daddr_req),
        .refill_active (refill_active),
        .wb_start      (wb_start),
        .line_we       (line_we),
        .store_hit_we  (store_hit_we),
        .set_dirty     (set_dirty)
    );

    dcache_line_store i_line_store (
        .clk          (clk),
        .rst          (rst),
        .daddr        (daddr),
        .line_we      (line_we),
        .fill_line    (fill_line),
        .store_hit_we (store_hit_we),
        .dwen         (dwen),
        .wdata        (wdata),
        .set_dirty    (set_dirty),
        .hit          (hit),
        .rd_line      (rd_line),
        .victim_tag   (victim_tag),
        .victim_dirty (victim_dirty)
    );

    dcache_refill i_refill (
        .clk           (clk),
        .rst           (rst),
        .refill_active (refill_active),
        .daddr         (daddr),
        .dwen          (dwen),
        .wdata         (wdata),
        .ddata_rvalid  (ddata_rvalid),
        .ddata_rdata   (ddata_rdata),
        .fill_line     (fill_line)
    );

    dcache_writeback i_writeback (
        .clk           (clk),
        .rst           (rst),
        .wb_start      (wb_start),
        .victim_tag    (victim_tag),
        .daddr         (daddr),
        .rd_line       (rd_line),
        .daddr_wreq_ok (daddr_wreq_ok),
        .ddata_wready  (ddata_wready),
        .ddata_bvalid  (ddata_bvalid),
        .wb_busy       (wb_busy),
        .write_en      (write_en),
        .daddr_wreq    (daddr_wreq),
        .write_byte_en (write_byte_en),
        .dwvalid       (dwvalid),
        .dwdata        (dwdata),
        .dwlast        (dwlast)
    );

endmodule

`default_nettype wire

/* tests/dcache_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module dcache_chk import dcache_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   den,
    input  logic   data_ok,
    input  logic   read_en,
    input  addr_t  daddr_req,
    input  logic   daddr_req_ok,
    input  logic   write_en,
    input  addr_t  daddr_wreq,
    input  logic   daddr_wreq_ok,
    input  logic   dwvalid,
    input  word_t  dwdata,
    input  logic   ddata_wready
);

    // Line read held until accepted
    read_req_held: assert property (
        @(posedge clk) disable iff (rst)
        read_en && !daddr_req_ok |=> read_en && $stable(daddr_req)
    ) else $error("read_en or daddr_req changed before daddr_req_ok");

    write_req_held: assert property (
        @(posedge clk) disable iff (rst)
        write_en && !daddr_wreq_ok |=> write_en && $stable(daddr_wreq)
    ) else $error("write_en or daddr_wreq changed before daddr_wreq_ok");

    // Beat stays on the bus until taken
    write_beat_held: assert property (
        @(posedge clk) disable iff (rst)
        dwvalid && !ddata_wready |=> dwvalid && $stable(dwdata)
    ) else $error("dwvalid or dwdata changed before ddata_wready");

    data_ok_with_den: assert property (
        @(posedge clk) disable iff (rst)
        data_ok |-> den
    ) else $error("data_ok high without den");

    reset_quiet: assert property (
        @(posedge clk)
        rst |=> !read_en && !dwvalid
    ) else $error("read_en or dwvalid high in the cycle after reset");

endmodule

`default_nettype wire

/* tests/dcache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dcache_params.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int CLK_PERIOD      = 100;
    localparam int REQ_LIMIT       = 2000;
    localparam int WATCHDOG_CYCLES = 40000;   // About four times the summed worst case

    logic   clk;
    logic   rst;
    logic   den;
    be_t    dwen;
    addr_t  daddr;
    word_t  wdata;
    logic   data_ok;
    word_t  data_data;
    logic   busy;
    logic   read_en;
    addr_t  daddr_req;
    logic   daddr_req_ok;
    word_t  ddata_rdata;
    logic   ddata_rvalid;
    logic   ddata_rlast;
    logic   write_en;
    addr_t  daddr_wreq;
    be_t    write_byte_en;
    logic   dwvalid;
    word_t  dwdata;
    logic   dwlast;
    logic   daddr_wreq_ok;
    logic   ddata_wready;
    logic   ddata_bvalid;

    int     seed;
    int     errors;
    int     start_errors;
    int     tests_run;
    int     tests_failed;
    word_t  shadow    [addr_t];   // Processor view, initial words plus issued stores
    word_t  mem_words [addr_t];   // Words written by write-back bursts
    logic   rd_active;
    logic   wr_active;
    logic   resp_pending;
    addr_t  rd_addr;
    addr_t  wr_addr;
    int     rd_beat;
    int     wr_beat;
    int     rd_count;
    int     wb_count;

    dcache_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .den           (den),
        .dwen          (dwen),
        .daddr         (daddr),
        .wdata         (wdata),
        .data_ok       (data_ok),
        .data_data     (data_data),
        .busy          (busy),
        .read_en       (read_en),
        .daddr_req     (daddr_req),
        .daddr_req_ok  (daddr_req_ok),
        .ddata_rdata   (ddata_rdata),
        .ddata_rvalid  (ddata_rvalid),
        .ddata_rlast   (ddata_rlast),
        .write_en      (write_en),
        .daddr_wreq    (daddr_wreq),
        .write_byte_en (write_byte_en),
        .dwvalid       (dwvalid),
        .dwdata        (dwdata),
        .dwlast        (dwlast),
        .daddr_wreq_ok (daddr_wreq_ok),
        .ddata_wready  (ddata_wready),
        .ddata_bvalid  (ddata_bvalid)
    );

    bind dcache_top dcache_chk i_chk (
        .clk           (clk),
        .rst           (rst),
        .den           (den),
        .data_ok       (data_ok),
        .read_en       (read_en),
        .daddr_req     (daddr_req),
        .daddr_req_ok  (daddr_req_ok),
        .write_en      (write_en),
        .daddr_wreq    (daddr_wreq),
        .daddr_wreq_ok (daddr_wreq_ok),
        .dwvalid       (dwvalid),
        .dwdata        (dwdata),
        .ddata_wready  (ddata_wready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic stall_bit();
        int r;
        r = $random(seed);
        return r[1:0] != 2'b00;   // Ready three cycles out of four
    endfunction

    function automatic addr_t line_of(input addr_t a);
        return {a[31:6], 6'b0};
    endfunction

    function automatic addr_t beat_addr(input addr_t base, input int beat);
        return base + addr_t'(beat * 4);
    endfunction

    function automatic word_t mem_word(input addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ 32'h5a5a5a5a;
    endfunction

    function automatic word_t expected_word(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a ^ 32'h5a5a5a5a;
    endfunction

    task automatic check_equal(input string name, input word_t exp, input word_t got);
        assert (got == exp) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond) else begin
            $display("Failure at %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // Holds the request until data_ok, sampled at the falling edge
    task automatic access(input addr_t addr, input be_t be, input word_t data,
                          output word_t rdata, output int latency);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        den   = 1'b1;
        dwen  = be;
        daddr = addr;
        wdata = data;
        @(negedge clk);
        while (!data_ok && n < REQ_LIMIT) begin
            check_true(busy, "busy low while a miss is outstanding");
            n++;
            @(negedge clk);
        end
        check_true(data_ok, "no data_ok before the request limit");
        rdata   = data_data;
        latency = n;
        @(posedge clk);
        #1;
        den  = 1'b0;
        dwen = '0;
    endtask

    task automatic load_check(input addr_t addr, output int latency);
        word_t got;
        access(addr, 4'b0000, 32'h0, got, latency);
        check_equal("data_data", expected_word(addr), got);
    endtask

    task automatic store(input addr_t addr, input be_t be, input word_t data,
                         output int latency);
        word_t mask;
        word_t unused;
        mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
        shadow[addr] = (expected_word(addr) & ~mask) | (data & mask);
        access(addr, be, data, unused, latency);
    endtask

    // Load into the index of a dirty line and check the burst it caused
    task automatic evict_check(input addr_t new_addr, input addr_t victim_line);
        int wb_before;
        int lat;
        wb_before = wb_count;
        load_check(new_addr, lat);
        check_true(wb_count == wb_before + 1, "dirty victim was not written back once");
        check_equal("daddr_wreq", victim_line, wr_addr);
        for (int i = 0; i < `DC_WORDS; i++) begin
            check_equal("mem_words", expected_word(beat_addr(victim_line, i)),
                        mem_word(beat_addr(victim_line, i)));
        end
    endtask

    task automatic random_mix(input int count);
        int r;
        int lat;
        addr_t a;
        for (int k = 0; k < count; k++) begin
            r = $random(seed);
            a = 32'h0004_0000 + (addr_t'(r[1:0]) << 13) + (addr_t'(r[3:2]) << 6)
                + (addr_t'(r[7:4]) << 2);   // Four tags over four indexes
            if (r[12] && r[11:8] != 4'b0000) begin
                store(a, r[11:8], $random(seed), lat);
            end else begin
                load_check(a, lat);
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == start_errors) begin
            $display("Test %0d %s passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s failed with %0d errors", tests_run, name,
                     errors - start_errors);
        end
        start_errors = errors;
    endtask

    // Bus memory model
    initial begin
        daddr_req_ok  = 1'b0;
        ddata_rdata   = '0;
        ddata_rvalid  = 1'b0;
        ddata_rlast   = 1'b0;
        daddr_wreq_ok = 1'b0;
        ddata_wready  = 1'b0;
        ddata_bvalid  = 1'b0;
        rd_active     = 1'b0;
        wr_active     = 1'b0;
        resp_pending  = 1'b0;
        rd_addr       = '0;
        wr_addr       = '0;
        rd_beat       = 0;
        wr_beat       = 0;
        rd_count      = 0;
        wb_count      = 0;
        forever begin
            @(posedge clk);
            #1;
            daddr_req_ok  = stall_bit();
            daddr_wreq_ok = stall_bit();
            ddata_wready  = stall_bit();
            ddata_bvalid  = resp_pending && stall_bit();
            ddata_rvalid  = rd_active && stall_bit();
            ddata_rdata   = ddata_rvalid ? mem_word(beat_addr(rd_addr, rd_beat)) : '0;
            ddata_rlast   = ddata_rvalid && (rd_beat == `DC_WORDS - 1);
            @(negedge clk);
            if (ddata_rvalid) begin
                rd_beat++;
                rd_active = !ddata_rlast;
            end
            if (read_en && daddr_req_ok) begin
                check_true(!rd_active, "line read requested during a refill");
                rd_active = 1'b1;
                rd_addr   = daddr_req;
                rd_beat   = 0;
                rd_count++;
            end
            if (write_en && daddr_wreq_ok) begin
                wr_active = 1'b1;
                wr_addr   = daddr_wreq;
                wr_beat   = 0;
            end
            if (dwvalid && ddata_wready) begin
                check_true(wr_active, "write beat before the write address was accepted");
                check_equal("write_byte_en", 32'hf, word_t'(write_byte_en));
                check_true(dwlast == (wr_beat == `DC_WORDS - 1),
                           "dwlast does not mark the 16th write beat");
                mem_words[beat_addr(wr_addr, wr_beat)] = dwdata;
                wr_beat++;
                if (dwlast) begin
                    wr_active    = 1'b0;
                    resp_pending = 1'b1;
                end
            end
            if (ddata_bvalid) begin
                resp_pending = 1'b0;
                wb_count++;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        addr_t addr_a;
        addr_t addr_b;
        int    lat;
        seed         = 32'ha794cc4b;
        errors       = 0;
        start_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        addr_a       = 32'h0001_2344;
        addr_b       = 32'h0001_2410;   // Same tag as addr_a, other index
        den          = 1'b0;
        dwen         = '0;
        daddr        = '0;
        wdata        = '0;
        rst          = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_true(!data_ok && !busy && !write_en,
                   "data_ok, busy or write_en high after reset");
        repeat (2) @(posedge clk);

        load_check(addr_a, lat);
        check_true(rd_count == 1, "first load did not issue exactly one line read");
        check_equal("daddr_req", line_of(addr_a), rd_addr);
        check_true(lat > 0, "first load after reset was answered as a hit");
        finish_test("cold miss");

        load_check(addr_a + 32'h38, lat);
        check_true(lat == 0 && rd_count == 1, "load in a resident line did not hit");
        finish_test("hit in same line");

        store(addr_a + 32'h8, 4'b0101, 32'hdeadbeef, lat);
        check_true(lat == 0, "store to a resident line did not hit");
        store(addr_b, 4'b1000, 32'hc0ffee11, lat);
        load_check(addr_a + 32'h8, lat);
        load_check(addr_b, lat);
        check_true(lat == 0, "load after a store miss did not hit");
        finish_test("partial stores");

        evict_check(addr_a + 32'h2000, line_of(addr_a));
        evict_check(addr_b + 32'h2000, line_of(addr_b));
        finish_test("dirty eviction");

        random_mix(64);
        finish_test("random mix under stalls");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
logic/dcache_pkg.sv
logic/dcache_line_store.sv
logic/dcache_refill.sv
logic/dcache_writeback.sv
logic/dcache_ctrl.sv
logic/dcache_top.sv
tests/dcache_chk.sv
tests/dcache_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module dcache_tb -o dcache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    exit 1
fi
exit 0
